// File: Makefile
TOP = tb_dma_initiator

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --assert --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: dma_initiator_sva.sv
// Protocol assertions for the DMA initiator top level.
// Bound into dma_initiator_top by the testbench, watches the request port,
// the Wishbone master and the NoC output.
`timescale 1ns/1ns

module dma_initiator_sva #(
  parameter int ADDR_WIDTH = 32
) (
  input logic                               clk,
  input logic                               rst,
  input logic                               req_valid,
  input logic                               req_ready,
  input logic [dma_pkg::DMA_SIZE_WIDTH-1:0] req_size,
  input logic                               wb_cyc,
  input logic                               wb_stb,
  input logic [ADDR_WIDTH-1:0]              wb_adr,
  input logic                               wb_ack,
  input logic                               noc_valid,
  input logic [noc_pkg::FLIT_WIDTH-1:0]     noc_flit,
  input logic                               noc_last,
  input logic                               noc_ready
);

  // No strobe outside a bus cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else $error("wb_stb high without wb_cyc");

  // Beat waits for its ack with a stable address
  a_adr_hold: assert property (@(posedge clk) disable iff (rst)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else $error("wb_adr or wb_stb changed before wb_ack");

  // Stalled flit stays on the link
  a_flit_hold: assert property (@(posedge clk) disable iff (rst)
    noc_valid && !noc_ready |=> noc_valid && $stable(noc_flit) && $stable(noc_last))
    else $error("noc_flit or noc_last changed under stall");

  // Zero length is illegal
  a_no_zero_size: assert property (@(posedge clk) disable iff (rst)
    req_valid && req_ready |-> req_size != '0)
    else $error("request accepted with req_size of zero");

endmodule

// File: dma_initiator_top.sv
// Top level of the DMA initiator read side.
// Connects the request controller, the Wishbone bus unit and the NoC
// packetizer. Request, Wishbone and NoC signals are plain ports.
`timescale 1ns/1ns

module dma_initiator_top #(
  parameter int ADDR_WIDTH = 32,
  parameter int NODE_ID    = 3
) (
  input  logic                               clk,
  input  logic                               rst,

  // Request port
  input  logic                               req_valid,
  output logic                               req_ready,
  input  logic [noc_pkg::NODE_ID_WIDTH-1:0]  req_dest,
  input  logic [ADDR_WIDTH-1:0]              req_laddr,
  input  logic [dma_pkg::DMA_SIZE_WIDTH-1:0] req_size,

  // Wishbone classic master
  output logic                               wb_cyc,
  output logic                               wb_stb,
  output logic [ADDR_WIDTH-1:0]              wb_adr,
  input  logic [noc_pkg::FLIT_WIDTH-1:0]     wb_dat_i,
  input  logic                               wb_ack,

  // NoC output
  output logic                               noc_valid,
  output logic [noc_pkg::FLIT_WIDTH-1:0]     noc_flit,
  output logic                               noc_last,
  input  logic                               noc_ready
);

  // Stream between bus unit and packetizer
  logic                           fifo_valid;
  logic [noc_pkg::FLIT_WIDTH-1:0] fifo_data;
  logic                           fifo_ready;

  dma_req_if #(.ADDR_WIDTH(ADDR_WIDTH)) req_bus ();

  dma_req_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) i_dma_req_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_dest  (req_dest),
    .req_laddr (req_laddr),
    .req_size  (req_size),
    .req       (req_bus.ctrl)
  );

  dma_req_biu #(.ADDR_WIDTH(ADDR_WIDTH)) i_dma_req_biu (
    .clk        (clk),
    .rst        (rst),
    .req        (req_bus.biu),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_ready (fifo_ready)
  );

  // Flit union leaves as a plain word
  dma_noc_packetizer #(.NODE_ID(NODE_ID)) i_dma_noc_packetizer (
    .clk        (clk),
    .rst        (rst),
    .req        (req_bus.pkt),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_ready (fifo_ready),
    .noc_valid  (noc_valid),
    .noc_flit   (noc_flit),
    .noc_last   (noc_last),
    .noc_ready  (noc_ready)
  );

endmodule

// File: dma_noc_packetizer.sv
// NoC packetizer of the DMA initiator.
// Sends one header flit per request, then forwards the FIFO words as data
// flits, marks the final flit with noc_last and signals done on its transfer.
`timescale 1ns/1ns

module dma_noc_packetizer #(
  parameter int NODE_ID = 3
) (
  input  logic                            clk,
  input  logic                            rst,

  // Latched request
  dma_req_if.pkt                          req,

  // Words from the bus unit
  input  logic                            fifo_valid,
  input  logic [noc_pkg::FLIT_WIDTH-1:0]  fifo_data,
  output logic                            fifo_ready,

  // NoC output
  output logic                            noc_valid,
  output noc_pkg::noc_flit_u              noc_flit,
  output logic                            noc_last,
  input  logic                            noc_ready
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_HDR  = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;

  logic [1:0] state;
  logic       hdr_phase;
  logic       in_data;
  logic       last_flit;
  // Data flits accepted so far
  logic [dma_pkg::DMA_SIZE_WIDTH-1:0] cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Flit selection
  ////////////////////////////////////////////////////////////////////////////

  // Header goes out with start and holds while stalled
  assign hdr_phase = ((state == ST_IDLE) & req.start) | (state == ST_HDR);
  assign in_data   = (state == ST_DATA);
  assign last_flit = (cnt == req.size - 1'b1);

  assign noc_valid  = hdr_phase | (in_data & fifo_valid);
  assign noc_last   = in_data & fifo_valid & last_flit;
  assign fifo_ready = in_data & noc_ready;
  assign req.done   = noc_last & noc_ready;

  always_comb begin
    if (in_data) begin
      noc_flit.data = fifo_data;
    end else begin
      noc_flit.hdr.dest = req.dest;
      noc_flit.hdr.src  = noc_pkg::NODE_ID_WIDTH'(NODE_ID);
      noc_flit.hdr.rsvd = '0;
      noc_flit.hdr.size = req.size;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req.start) begin
            state <= noc_ready ? ST_DATA : ST_HDR;
          end
        end
        ST_HDR: begin
          if (noc_ready) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (fifo_valid & noc_ready) begin
            cnt <= cnt + 1'b1;
            if (last_flit) begin
              state <= ST_IDLE;
              cnt   <= '0;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: dma_pkg.sv
// Request definitions for the read side of the DMA initiator.
// The request controller latches a dma_req_t, and the bus unit and the
// packetizer see its fields through the request interface.
package dma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Request fields
  ////////////////////////////////////////////////////////////////////////////

  // Transfer length in words, zero is illegal
  localparam int DMA_SIZE_WIDTH = 16;

  // Latched request
  // The local address width is a module parameter, so the address
  // travels next to this record as its own signal
  typedef struct packed {
    // Target tile on the NoC
    logic [noc_pkg::NODE_ID_WIDTH-1:0] dest;
    // Words to move
    logic [DMA_SIZE_WIDTH-1:0]         size;
  } dma_req_t;

endpackage

// File: dma_req_biu.sv
// Bus interface unit of the DMA initiator.
// Reads the requested words from local memory as a Wishbone classic master
// and stores them in a three-entry FIFO that feeds the packetizer.
// Reading pauses at the FIFO high-water mark and resumes below it.
`timescale 1ns/1ns

module dma_req_biu #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                            clk,
  input  logic                            rst,

  // Latched request
  dma_req_if.biu                          req,

  // Wishbone classic read master
  output logic                            wb_cyc,
  output logic                            wb_stb,
  output logic [ADDR_WIDTH-1:0]           wb_adr,
  input  logic [noc_pkg::FLIT_WIDTH-1:0]  wb_dat_i,
  input  logic                            wb_ack,

  // Word stream to the packetizer
  output logic                            fifo_valid,
  output logic [noc_pkg::FLIT_WIDTH-1:0]  fifo_data,
  input  logic                            fifo_ready
);

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_DATA = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;

  logic [1:0] state;
  logic [1:0] state_nxt;

  // Words acknowledged so far in this request
  logic [dma_pkg::DMA_SIZE_WIDTH-1:0] cnt;
  logic [dma_pkg::DMA_SIZE_WIDTH-1:0] cnt_nxt;
  logic                               last_word;

  // Beat on the bus this cycle
  logic beat;

  // Shift FIFO, entry 0 is the head
  logic [noc_pkg::FLIT_WIDTH-1:0] mem [3];
  // One-hot fill level, bit 0 empty up to bit 3 full
  logic [3:0] pos;
  logic       push;
  logic       pop;
  logic       high_water;

  ////////////////////////////////////////////////////////////////////////////
  // FIFO
  ////////////////////////////////////////////////////////////////////////////

  assign fifo_valid = ~pos[0];
  assign fifo_data  = mem[0];
  assign pop        = fifo_valid & fifo_ready;

  // Two or more entries stored
  assign high_water = pos[2] | pos[3];

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= 4'b0001;
    end else if (push & ~pop) begin
      pos <= pos << 1;
    end else if (pop & ~push) begin
      pos <= pos >> 1;
    end
  end

  // On pop every entry moves down, a push lands one below its level
  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (pop) begin
        if (push && pos[i+1]) begin
          mem[i] <= wb_dat_i;
        end else begin
          mem[i] <= mem[(i < 2) ? i + 1 : 2];
        end
      end else if (push && pos[i]) begin
        mem[i] <= wb_dat_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////////////////////////////////////////

  assign last_word = (cnt == req.size - 1'b1);

  // Base plus four bytes per word
  assign wb_adr = req.laddr + (ADDR_WIDTH'(cnt) << 2);
  assign wb_cyc = beat;
  assign wb_stb = beat;

  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;
    beat      = 1'b0;
    push      = 1'b0;

    case (state)
      ST_IDLE: begin
        // FIFO is empty here, so the first beat goes out with start
        beat = req.start;
      end
      ST_DATA: begin
        beat = 1'b1;
      end
      ST_WAIT: begin
        // Restart once below the mark
        if (!high_water) begin
          state_nxt = ST_DATA;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase

    if (beat) begin
      state_nxt = ST_DATA;
      if (wb_ack) begin
        push    = 1'b1;
        cnt_nxt = cnt + 1'b1;
        if (last_word) begin
          // Transfer complete, counter ready for the next one
          state_nxt = ST_IDLE;
          cnt_nxt   = '0;
        end else if (high_water) begin
          // Drop cyc after this ack until the FIFO drains
          state_nxt = ST_WAIT;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

endmodule

// File: dma_req_ctrl.sv
// Request controller of the DMA initiator.
// Takes one request at a time from the request port, pulses start and holds
// the latched fields on the request bundle until the packetizer reports done.
`timescale 1ns/1ns

module dma_req_ctrl #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                               clk,
  input  logic                               rst,

  // Request port
  input  logic                               req_valid,
  output logic                               req_ready,
  input  logic [noc_pkg::NODE_ID_WIDTH-1:0]  req_dest,
  input  logic [ADDR_WIDTH-1:0]              req_laddr,
  input  logic [dma_pkg::DMA_SIZE_WIDTH-1:0] req_size,

  // Latched request towards bus unit and packetizer
  dma_req_if.ctrl                            req
);

  ////////////////////////////////////////////////////////////////////////////
  // State and storage
  ////////////////////////////////////////////////////////////////////////////

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_BUSY = 1'b1;

  logic              state;
  logic              start_q;
  dma_pkg::dma_req_t req_q;
  logic [ADDR_WIDTH-1:0] laddr_q;
  logic              accept;

  // Only idle can take a new request
  assign req_ready = (state == ST_IDLE);
  assign accept    = req_valid & req_ready;

  // Two-state FSM, start follows acceptance by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_BUSY;
          end
        end
        default: begin
          // Back to idle once the last flit is gone
          if (req.done) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Request fields, loaded on acceptance only
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q.dest <= req_dest;
      req_q.size <= req_size;
      laddr_q    <= req_laddr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bundle outputs
  ////////////////////////////////////////////////////////////////////////////

  assign req.start = start_q;
  assign req.dest  = req_q.dest;
  assign req.size  = req_q.size;
  assign req.laddr = laddr_q;

endmodule

// File: dma_req_if.sv
// Request bundle inside the DMA initiator.
// The controller drives the latched request and a start pulse.
// The packetizer answers with done when the last flit has left.
`timescale 1ns/1ns

interface dma_req_if #(
  parameter int ADDR_WIDTH = 32
);

  // One-cycle pulse when a request is taken
  logic                               start;
  // Fields stay stable from start until done
  logic [noc_pkg::NODE_ID_WIDTH-1:0]  dest;
  logic [ADDR_WIDTH-1:0]              laddr;
  logic [dma_pkg::DMA_SIZE_WIDTH-1:0] size;
  // Last data flit accepted by the NoC
  logic                               done;

  // Request controller
  modport ctrl (output start, dest, laddr, size, input done);

  // Wishbone side only needs where and how much
  modport biu (input start, laddr, size);

  // NoC side builds the header and ends the request
  modport pkt (input start, dest, size, output done);

endinterface

// File: noc_pkg.sv
// NoC flit definitions for the DMA initiator tile
// Flit width, node id width and the two views of a flit.
// The packetizer builds flits with these types, and the testbench decodes them.
package noc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // One flit carries one memory word
  localparam int FLIT_WIDTH = 32;

  // Node id on the mesh
  localparam int NODE_ID_WIDTH = 5;

  // Header fields below the two node ids
  localparam int HDR_RSVD_WIDTH = 6;
  localparam int HDR_SIZE_WIDTH = FLIT_WIDTH - 2 * NODE_ID_WIDTH - HDR_RSVD_WIDTH;

  ////////////////////////////////////////////////////////////////////////////
  // Flit views
  ////////////////////////////////////////////////////////////////////////////

  // Header view, first flit of every packet
  typedef struct packed {
    logic [NODE_ID_WIDTH-1:0]  dest;
    logic [NODE_ID_WIDTH-1:0]  src;
    // Always zero
    logic [HDR_RSVD_WIDTH-1:0] rsvd;
    // Number of data flits after the header
    logic [HDR_SIZE_WIDTH-1:0] size;
  } noc_header_t;

  // Same word seen either as header or as raw data
  typedef union packed {
    noc_header_t           hdr;
    logic [FLIT_WIDTH-1:0] data;
  } noc_flit_u;

endpackage

// File: tb.f
noc_pkg.sv
dma_pkg.sv
dma_req_if.sv
dma_req_ctrl.sv
dma_req_biu.sv
dma_noc_packetizer.sv
dma_initiator_top.sv
dma_initiator_sva.sv
tb_dma_initiator.sv

// File: tb_dma_initiator.sv
// Testbench for the DMA initiator read side.
// Applies a table of requests, answers Wishbone reads from a memory model with
// random wait states and sinks NoC flits under three back-pressure modes.
// Every header, data flit and Wishbone address is compared with expected values.
`timescale 1ns/1ns

module tb_dma_initiator;

  localparam int         NODE_ID     = 3;
  localparam int         NUM_TESTS   = 6;
  localparam logic [1:0] MODE_READY  = 2'd0;
  localparam logic [1:0] MODE_RANDOM = 2'd1;
  localparam logic [1:0] MODE_STALL  = 2'd2;

  // One request and the NoC sink behavior during it
  typedef struct packed {
    logic [4:0]  dest;
    logic [31:0] laddr;
    logic [15:0] size;
    logic [1:0]  mode;
  } test_entry_t;

  logic        clk;
  logic        rst;
  logic        req_valid;
  logic        req_ready;
  logic [4:0]  req_dest;
  logic [31:0] req_laddr;
  logic [15:0] req_size;
  logic        wb_cyc;
  logic        wb_stb;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_i;
  logic        wb_ack;
  logic        noc_valid;
  logic [31:0] noc_flit;
  logic        noc_last;
  logic        noc_ready;

  test_entry_t tests [NUM_TESTS];
  integer      seed = 32'hface;
  logic [31:0] rnd;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          timeout_limit = 0;
  logic [1:0]  stall_mode = MODE_READY;
  int          stall_cnt = 0;
  int          mem_wait = 0;
  bit          mem_busy = 1'b0;
  // Monitor flags
  bit          busy = 1'b0;
  bit          check_launch = 1'b0;
  bit          check_idle = 1'b0;
  bit          xfer_done = 1'b0;
  // Collected per request
  logic [31:0] adr_q [$];
  logic [31:0] flit_q [$];
  logic        last_q [$];

  dma_initiator_top #(.NODE_ID(NODE_ID)) i_dma_initiator_top (.*);

  bind dma_initiator_top dma_initiator_sva #(.ADDR_WIDTH(ADDR_WIDTH)) i_dma_initiator_sva (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic end_run(input bit timed_out);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and NoC sink on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : bus_models
    rnd = $random(seed);
    if (rst || !wb_stb) begin
      wb_ack   = 1'b0;
      mem_busy = 1'b0;
    end else begin
      // New beat picks 0 to 3 wait cycles
      if (!mem_busy) begin
        mem_wait = int'(rnd[1:0]);
        mem_busy = 1'b1;
      end
      if (mem_wait == 0) begin
        wb_ack   = 1'b1;
        wb_dat_i = wb_adr ^ 32'h5a5a_0000;
        mem_busy = 1'b0;
      end else begin
        wb_ack   = 1'b0;
        mem_wait = mem_wait - 1;
      end
    end
    stall_cnt = stall_cnt + 1;
    case (stall_mode)
      MODE_RANDOM: noc_ready = rnd[4];
      // One ready cycle in eight
      MODE_STALL:  noc_ready = (stall_cnt % 8 == 0);
      default:     noc_ready = 1'b1;
    endcase
  end

  // Samples once the falling edge inputs settle
  // Transfers seen here land on the next rising edge
  always @(negedge clk) begin : monitor
    #1;
    if (!rst) begin
      if (check_idle) begin
        check("req_ready after last flit", 32'(req_ready), 32'd1);
        check_idle = 1'b0;
      end
      if (check_launch) begin
        check("wb_cyc after accept", 32'(wb_cyc), 32'd1);
        check("noc_valid after accept", 32'(noc_valid), 32'd1);
        check_launch = 1'b0;
      end
      if (busy) begin
        check("req_ready while busy", 32'(req_ready), 32'd0);
      end
      if (req_valid && req_ready) begin
        busy         = 1'b1;
        check_launch = 1'b1;
      end
      if (wb_stb && wb_ack) begin
        adr_q.push_back(wb_adr);
      end
      if (noc_valid && noc_ready) begin
        flit_q.push_back(noc_flit);
        last_q.push_back(noc_last);
        if (noc_last) begin
          busy       = 1'b0;
          check_idle = 1'b1;
          xfer_done  = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles = cycles + 1;
    if (cycles > timeout_limit) begin
      $display("Timeout: requests did not complete within %0d cycles", timeout_limit);
      end_run(1'b1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request table
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int                 i;
    int                 k;
    int                 total;
    logic [31:0]        addr;
    noc_pkg::noc_flit_u flit;

    rst       = 1'b1;
    req_valid = 1'b0;
    req_dest  = '0;
    req_laddr = '0;
    req_size  = '0;
    wb_dat_i  = '0;
    wb_ack    = 1'b0;
    noc_ready = 1'b0;

    tests[0] = '{5'd7,  32'h0000_1000, 16'd1,  MODE_READY};
    tests[1] = '{5'd1,  32'h0000_2004, 16'd5,  MODE_READY};
    tests[2] = '{5'd30, 32'h0001_0100, 16'd8,  MODE_RANDOM};
    tests[3] = '{5'd12, 32'h0000_3ff0, 16'd6,  MODE_STALL};
    tests[4] = '{5'd3,  32'hfffe_fff8, 16'd4,  MODE_RANDOM};
    tests[5] = '{5'd0,  32'h0000_0040, 16'd12, MODE_READY};

    // Sixteen cycles per word plus slack for reset and gaps
    total = 0;
    for (i = 0; i < NUM_TESTS; i++) begin
      total += int'(tests[i].size);
    end
    timeout_limit = total * 16 + 200;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    #1;
    check("wb_cyc after reset", 32'(wb_cyc), 32'd0);
    check("noc_valid after reset", 32'(noc_valid), 32'd0);
    check("req_ready after reset", 32'(req_ready), 32'd1);

    for (i = 0; i < NUM_TESTS; i++) begin
      @(negedge clk);
      flit_q.delete();
      last_q.delete();
      adr_q.delete();
      xfer_done  = 1'b0;
      stall_mode = tests[i].mode;
      req_valid  = 1'b1;
      req_dest   = tests[i].dest;
      req_laddr  = tests[i].laddr;
      req_size   = tests[i].size;
      @(negedge clk);
      req_valid = 1'b0;
      wait (xfer_done);

      // Header then size data flits and one Wishbone read per word
      check("flit count", 32'(flit_q.size()), 32'(tests[i].size) + 32'd1);
      check("wb read count", 32'(adr_q.size()), 32'(tests[i].size));
      flit = flit_q[0];
      check("noc_flit hdr.dest", 32'(flit.hdr.dest), 32'(tests[i].dest));
      check("noc_flit hdr.src", 32'(flit.hdr.src), 32'(NODE_ID));
      check("noc_flit hdr.rsvd", 32'(flit.hdr.rsvd), 32'd0);
      check("noc_flit hdr.size", 32'(flit.hdr.size), 32'(tests[i].size));
      check("noc_last on header", 32'(last_q[0]), 32'd0);
      for (k = 0; k < int'(tests[i].size); k++) begin
        addr = tests[i].laddr + 32'(4 * k);
        if (k + 1 < flit_q.size()) begin
          flit = flit_q[k + 1];
          check("noc_flit data", flit.data, addr ^ 32'h5a5a_0000);
          check("noc_last", 32'(last_q[k + 1]), 32'(k == int'(tests[i].size) - 1));
        end
        if (k < adr_q.size()) begin
          check("wb_adr", adr_q[k], addr);
        end
      end
    end

    // Let the monitor see req_ready return after the last request
    repeat (2) @(negedge clk);
    end_run(1'b0);
  end

endmodule
